//--- source/bank_line_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module bank_line_store (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [`CACHE_SET_BITS-1:0]    rd_set,
    output logic                          rd_valid,
    output logic [`CACHE_TAG_BITS-1:0]    rd_tag,
    output logic [`CACHE_LINE_BITS-1:0]   rd_line,

    input  logic                          wr_en,
    input  logic [`CACHE_SET_BITS-1:0]    wr_set,
    input  logic [`CACHE_TAG_BITS-1:0]    wr_tag,
    input  logic [`CACHE_LINE_BITS-1:0]   wr_line
);

    logic [`CACHE_SETS-1:0]        valid_bits;
    logic [`CACHE_TAG_BITS-1:0]    tag_mem  [`CACHE_SETS];
    logic [`CACHE_LINE_BITS-1:0]   line_mem [`CACHE_SETS];
    logic [`CACHE_SET_BITS-1:0]    rd_set_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (wr_en) begin
            valid_bits[wr_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_set]  <= wr_tag;
            line_mem[wr_set] <= wr_line;
        end
        rd_set_q <= rd_set;
    end

    // Read port, one cycle behind the address
    assign rd_valid = valid_bits[rd_set_q];
    assign rd_tag   = tag_mem[rd_set_q];
    assign rd_line  = line_mem[rd_set_q];

endmodule

`default_nettype wire

//--- source/cache_addr_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_addr_pkg;

    // Byte address as seen by the core
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]      tag;
        logic [`CACHE_SET_BITS-1:0]      set;
        logic [`CACHE_BANK_BITS-1:0]     bank;
        logic [`CACHE_WORD_SEL_BITS-1:0] word_sel;
        logic [1:0]                      byte_off;
    } byte_addr_fields_s;

    typedef union packed {
        logic [31:0]       raw;
        byte_addr_fields_s f;
    } byte_addr_u;

    // Line address, also used as the DRAM tag
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]  tag;
        logic [`CACHE_SET_BITS-1:0]  set;
        logic [`CACHE_BANK_BITS-1:0] bank;
    } line_addr_fields_s;

    typedef union packed {
        logic [`CACHE_LINE_ADDR_BITS-1:0] raw;
        line_addr_fields_s                f;
    } line_addr_u;

endpackage

`default_nettype wire

//--- source/cache_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_bank (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        req_valid,
    input  cache_bus_pkg::core_req_s    req,
    output logic                        req_ready,

    output logic                        rsp_valid,
    output cache_bus_pkg::core_rsp_s    rsp,
    input  logic                        rsp_ready,

    output logic                        fill_req_valid,
    output cache_bus_pkg::fill_req_s    fill_req,
    input  logic                        fill_req_ready,

    input  logic                        fill_rsp_valid,
    input  cache_bus_pkg::fill_rsp_s    fill_rsp,
    output logic                        fill_rsp_ready
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL_REQ,
        S_FILL_WAIT,
        S_RESPOND
    } state_e;

    state_e                          state;
    logic                            fill_pend;
    cache_bus_pkg::core_req_s        req_q;
    cache_bus_pkg::fill_rsp_s        fill_q;

    logic                            rd_valid;
    logic [`CACHE_TAG_BITS-1:0]      rd_tag;
    logic [`CACHE_LINE_BITS-1:0]     rd_line;
    logic [`CACHE_LINE_BITS-1:0]     lookup_line;
    logic [`CACHE_WORD_BITS-1:0]     lookup_word;
    logic                            hit;

    // Storage is read while the request is offered in idle
    bank_line_store u_store (
        .clk      (clk),
        .rst      (rst),
        .rd_set   (req.addr.f.set),
        .rd_valid (rd_valid),
        .rd_tag   (rd_tag),
        .rd_line  (rd_line),
        .wr_en    (state == S_LOOKUP && fill_pend),
        .wr_set   (fill_q.addr.f.set),
        .wr_tag   (fill_q.addr.f.tag),
        .wr_line  (fill_q.data)
    );

    // Returning from a fill, the lookup takes the fetched line
    assign hit = fill_pend || (rd_valid && rd_tag == req_q.addr.f.tag);
    assign lookup_line = fill_pend ? fill_q.data : rd_line;

    always_comb begin
        lookup_word = '0;
        for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++) begin
            if (req_q.addr.f.word_sel == w) begin
                lookup_word = lookup_line[w*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            fill_pend <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (req_valid) state <= S_LOOKUP;
                S_LOOKUP: begin
                    fill_pend <= 1'b0;
                    state     <= hit ? S_RESPOND : S_FILL_REQ;
                end
                S_FILL_REQ: if (fill_req_ready) state <= S_FILL_WAIT;
                S_FILL_WAIT: begin
                    if (fill_rsp_valid) begin
                        fill_pend <= 1'b1;
                        state     <= S_LOOKUP;
                    end
                end
                S_RESPOND: if (rsp_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            req_q <= req;
        end
        if (state == S_FILL_WAIT && fill_rsp_valid) begin
            fill_q <= fill_rsp;
        end
        if (state == S_LOOKUP && hit) begin
            rsp.data <= lookup_word;
            rsp.tag  <= req_q.tag;
        end
    end

    assign req_ready      = (state == S_IDLE);
    assign rsp_valid      = (state == S_RESPOND);
    assign fill_req_valid = (state == S_FILL_REQ);
    assign fill_rsp_ready = (state == S_FILL_WAIT);

    assign fill_req.addr.f.tag  = req_q.addr.f.tag;
    assign fill_req.addr.f.set  = req_q.addr.f.set;
    assign fill_req.addr.f.bank = req_q.addr.f.bank;

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("bank response changed while stalled");

    // Fills are routed to a bank only while it waits for one
    a_fill_routed: assert property (@(posedge clk) disable iff (rst)
        fill_rsp_valid |-> state == S_FILL_WAIT)
        else $error("fill response outside fill wait");

endmodule

`default_nettype wire

//--- source/cache_bus_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_bus_pkg;

    // Core request, read only
    typedef struct packed {
        cache_addr_pkg::byte_addr_u       addr;
        logic [`CACHE_CORE_TAG_BITS-1:0]  tag;
    } core_req_s;

    // Core response
    typedef struct packed {
        logic [`CACHE_WORD_BITS-1:0]      data;
        logic [`CACHE_CORE_TAG_BITS-1:0]  tag;
    } core_rsp_s;

    // Line fetch from a bank
    typedef struct packed {
        cache_addr_pkg::line_addr_u       addr;
    } fill_req_s;

    // Returned line, routed back by address
    typedef struct packed {
        cache_addr_pkg::line_addr_u       addr;
        logic [`CACHE_LINE_BITS-1:0]      data;
    } fill_rsp_s;

endpackage

`default_nettype wire

//--- source/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Bank geometry
`define CACHE_NUM_BANKS       4
`define CACHE_BANK_BITS       2

// Line layout
`define CACHE_WORDS_PER_LINE  4
`define CACHE_WORD_SEL_BITS   2
`define CACHE_WORD_BITS       32
`define CACHE_LINE_BITS       128

// Sets per bank, direct mapped
`define CACHE_SETS            16
`define CACHE_SET_BITS        4
`define CACHE_TAG_BITS        22

`define CACHE_LINE_ADDR_BITS  28
`define CACHE_CORE_TAG_BITS   8

`endif

//--- source/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_top (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                core_req_valid,
    input  cache_bus_pkg::core_req_s            core_req,
    output logic                                core_req_ready,

    output logic                                core_rsp_valid,
    output cache_bus_pkg::core_rsp_s            core_rsp,
    input  logic                                core_rsp_ready,

    output logic                                dram_req_read,
    output logic [`CACHE_LINE_ADDR_BITS-1:0]    dram_req_addr,
    output logic [`CACHE_LINE_ADDR_BITS-1:0]    dram_req_tag,
    input  logic                                dram_req_ready,

    input  logic                                dram_rsp_valid,
    input  logic [`CACHE_LINE_BITS-1:0]         dram_rsp_data,
    input  logic [`CACHE_LINE_ADDR_BITS-1:0]    dram_rsp_tag,
    output logic                                dram_rsp_ready
);

    logic [`CACHE_NUM_BANKS-1:0]                      bank_req_valid;
    cache_bus_pkg::core_req_s                         bank_req;
    logic [`CACHE_NUM_BANKS-1:0]                      bank_req_ready;
    logic [`CACHE_NUM_BANKS-1:0]                      bank_rsp_valid;
    cache_bus_pkg::core_rsp_s [`CACHE_NUM_BANKS-1:0]  bank_rsp;
    logic [`CACHE_NUM_BANKS-1:0]                      bank_rsp_ready;
    logic [`CACHE_NUM_BANKS-1:0]                      fill_req_valid;
    cache_bus_pkg::fill_req_s [`CACHE_NUM_BANKS-1:0]  fill_req;
    logic [`CACHE_NUM_BANKS-1:0]                      fill_req_ready;
    logic [`CACHE_NUM_BANKS-1:0]                      fill_rsp_valid;
    cache_bus_pkg::fill_rsp_s                         fill_rsp;
    logic [`CACHE_NUM_BANKS-1:0]                      fill_rsp_ready;

    core_req_dispatch u_dispatch (
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_req_ready (bank_req_ready)
    );

    for (genvar b = 0; b < `CACHE_NUM_BANKS; b++) begin : g_bank
        cache_bank u_bank (
            .clk            (clk),
            .rst            (rst),
            .req_valid      (bank_req_valid[b]),
            .req            (bank_req),
            .req_ready      (bank_req_ready[b]),
            .rsp_valid      (bank_rsp_valid[b]),
            .rsp            (bank_rsp[b]),
            .rsp_ready      (bank_rsp_ready[b]),
            .fill_req_valid (fill_req_valid[b]),
            .fill_req       (fill_req[b]),
            .fill_req_ready (fill_req_ready[b]),
            .fill_rsp_valid (fill_rsp_valid[b]),
            .fill_rsp       (fill_rsp),
            .fill_rsp_ready (fill_rsp_ready[b])
        );
    end

    dram_port u_dram_port (
        .clk            (clk),
        .rst            (rst),
        .fill_req_valid (fill_req_valid),
        .fill_req       (fill_req),
        .fill_req_ready (fill_req_ready),
        .dram_req_read  (dram_req_read),
        .dram_req_addr  (dram_req_addr),
        .dram_req_tag   (dram_req_tag),
        .dram_req_ready (dram_req_ready),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp_data  (dram_rsp_data),
        .dram_rsp_tag   (dram_rsp_tag),
        .dram_rsp_ready (dram_rsp_ready),
        .fill_rsp_valid (fill_rsp_valid),
        .fill_rsp       (fill_rsp),
        .fill_rsp_ready (fill_rsp_ready)
    );

    core_rsp_merge u_rsp_merge (
        .clk            (clk),
        .rst            (rst),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_rsp_ready (bank_rsp_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready)
    );

endmodule

`default_nettype wire

//--- source/core_req_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module core_req_dispatch (
    input  logic                              core_req_valid,
    input  cache_bus_pkg::core_req_s          core_req,
    output logic                              core_req_ready,

    output logic [`CACHE_NUM_BANKS-1:0]       bank_req_valid,
    output cache_bus_pkg::core_req_s          bank_req,
    input  logic [`CACHE_NUM_BANKS-1:0]       bank_req_ready
);

    logic [`CACHE_BANK_BITS-1:0] bank_sel;

    // Bank bits sit just above the word select
    assign bank_sel = core_req.addr.f.bank;

    always_comb begin
        bank_req_valid = '0;
        bank_req_valid[bank_sel] = core_req_valid;
    end

    // All banks see the payload, only one sees valid
    assign bank_req = core_req;

    assign core_req_ready = bank_req_ready[bank_sel];

endmodule

`default_nettype wire

//--- source/core_rsp_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module core_rsp_merge (
    input  logic                                          clk,
    input  logic                                          rst,

    input  logic [`CACHE_NUM_BANKS-1:0]                   bank_rsp_valid,
    input  cache_bus_pkg::core_rsp_s [`CACHE_NUM_BANKS-1:0] bank_rsp,
    output logic [`CACHE_NUM_BANKS-1:0]                   bank_rsp_ready,

    output logic                                          core_rsp_valid,
    output cache_bus_pkg::core_rsp_s                      core_rsp,
    input  logic                                          core_rsp_ready
);

    logic [`CACHE_BANK_BITS-1:0] rr_ptr;
    logic [`CACHE_BANK_BITS-1:0] cand_idx;
    logic [`CACHE_BANK_BITS-1:0] grant_idx;
    logic                        grant_found;

    always_comb begin
        grant_idx   = rr_ptr;
        grant_found = 1'b0;
        cand_idx    = rr_ptr;
        for (int k = `CACHE_NUM_BANKS - 1; k >= 0; k--) begin
            cand_idx = rr_ptr + `CACHE_BANK_BITS'(k);
            if (bank_rsp_valid[cand_idx]) begin
                grant_idx   = cand_idx;
                grant_found = 1'b1;
            end
        end
    end

    // Held on a stalled bank, moves past it after the transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (grant_found) begin
            rr_ptr <= core_rsp_ready ? grant_idx + `CACHE_BANK_BITS'(1) : grant_idx;
        end
    end

    always_comb begin
        bank_rsp_ready = '0;
        bank_rsp_ready[grant_idx] = grant_found && core_rsp_ready;
    end

    assign core_rsp_valid = grant_found;
    assign core_rsp       = bank_rsp[grant_idx];

    a_one_ready: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bank_rsp_ready))
        else $error("more than one bank response accepted");

endmodule

`default_nettype wire

//--- source/dram_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module dram_port (
    input  logic                                          clk,
    input  logic                                          rst,

    input  logic [`CACHE_NUM_BANKS-1:0]                   fill_req_valid,
    input  cache_bus_pkg::fill_req_s [`CACHE_NUM_BANKS-1:0] fill_req,
    output logic [`CACHE_NUM_BANKS-1:0]                   fill_req_ready,

    output logic                                          dram_req_read,
    output logic [`CACHE_LINE_ADDR_BITS-1:0]              dram_req_addr,
    output logic [`CACHE_LINE_ADDR_BITS-1:0]              dram_req_tag,
    input  logic                                          dram_req_ready,

    input  logic                                          dram_rsp_valid,
    input  logic [`CACHE_LINE_BITS-1:0]                   dram_rsp_data,
    input  logic [`CACHE_LINE_ADDR_BITS-1:0]              dram_rsp_tag,
    output logic                                          dram_rsp_ready,

    output logic [`CACHE_NUM_BANKS-1:0]                   fill_rsp_valid,
    output cache_bus_pkg::fill_rsp_s                      fill_rsp,
    input  logic [`CACHE_NUM_BANKS-1:0]                   fill_rsp_ready
);

    logic [`CACHE_BANK_BITS-1:0] rr_ptr;
    logic [`CACHE_BANK_BITS-1:0] cand_idx;
    logic [`CACHE_BANK_BITS-1:0] grant_idx;
    logic                        grant_found;
    cache_addr_pkg::line_addr_u  rsp_line;

    // First valid bank at or after the pointer
    always_comb begin
        grant_idx   = rr_ptr;
        grant_found = 1'b0;
        cand_idx    = rr_ptr;
        for (int k = `CACHE_NUM_BANKS - 1; k >= 0; k--) begin
            cand_idx = rr_ptr + `CACHE_BANK_BITS'(k);
            if (fill_req_valid[cand_idx]) begin
                grant_idx   = cand_idx;
                grant_found = 1'b1;
            end
        end
    end

    // Pointer parks on a stalled winner so the grant holds
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (grant_found) begin
            rr_ptr <= dram_req_ready ? grant_idx + `CACHE_BANK_BITS'(1) : grant_idx;
        end
    end

    always_comb begin
        fill_req_ready = '0;
        fill_req_ready[grant_idx] = grant_found && dram_req_ready;
    end

    assign dram_req_read = grant_found;
    assign dram_req_addr = fill_req[grant_idx].addr.raw;
    assign dram_req_tag  = dram_req_addr;

    // Tag is the line address, its bank field picks the owner
    assign rsp_line.raw = dram_rsp_tag;

    always_comb begin
        fill_rsp_valid = '0;
        fill_rsp_valid[rsp_line.f.bank] = dram_rsp_valid;
    end

    assign fill_rsp.addr   = rsp_line;
    assign fill_rsp.data   = dram_rsp_data;
    assign dram_rsp_ready  = fill_rsp_ready[rsp_line.f.bank];

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        dram_req_read && !dram_req_ready |=> dram_req_read && $stable(dram_req_addr))
        else $error("DRAM request dropped or changed while stalled");

endmodule

`default_nettype wire

//--- verification/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_tb;

    localparam int TIMEOUT = 200;

    logic                                 clk;
    logic                                 rst;
    logic                                 core_req_valid;
    cache_bus_pkg::core_req_s             core_req;
    logic                                 core_req_ready;
    logic                                 core_rsp_valid;
    cache_bus_pkg::core_rsp_s             core_rsp;
    logic                                 core_rsp_ready;
    logic                                 dram_req_read;
    logic [`CACHE_LINE_ADDR_BITS-1:0]     dram_req_addr;
    logic [`CACHE_LINE_ADDR_BITS-1:0]     dram_req_tag;
    logic                                 dram_req_ready;
    logic                                 dram_rsp_valid;
    logic [`CACHE_LINE_BITS-1:0]          dram_rsp_data;
    logic [`CACHE_LINE_ADDR_BITS-1:0]     dram_rsp_tag;
    logic                                 dram_rsp_ready;
    int unsigned                          rsp_delay;
    logic                                 hold_ready;
    int unsigned                          read_count;
    logic [`CACHE_LINE_ADDR_BITS-1:0]     last_addr;
    int                                   errors;
    int                                   timeouts;
    logic                                 rsp_stalled;
    cache_bus_pkg::core_rsp_s             stalled_rsp;
    logic                                 dram_stalled;
    logic [`CACHE_LINE_ADDR_BITS-1:0]     stalled_addr;
    logic [`CACHE_LINE_ADDR_BITS-1:0]     stalled_tag;

    cache_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .dram_req_read  (dram_req_read),
        .dram_req_addr  (dram_req_addr),
        .dram_req_tag   (dram_req_tag),
        .dram_req_ready (dram_req_ready),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp_data  (dram_rsp_data),
        .dram_rsp_tag   (dram_rsp_tag),
        .dram_rsp_ready (dram_rsp_ready)
    );

    dram_model u_dram (
        .clk        (clk),
        .rst        (rst),
        .req_read   (dram_req_read),
        .req_addr   (dram_req_addr),
        .req_tag    (dram_req_tag),
        .req_ready  (dram_req_ready),
        .rsp_valid  (dram_rsp_valid),
        .rsp_data   (dram_rsp_data),
        .rsp_tag    (dram_rsp_tag),
        .rsp_ready  (dram_rsp_ready),
        .rsp_delay  (rsp_delay),
        .hold_ready (hold_ready),
        .read_count (read_count),
        .last_addr  (last_addr)
    );

    always #5 clk = ~clk;

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out waiting for %s at %0t", what, $time);
    endtask

    // Memory rule
    function automatic logic [31:0] rule_word(input logic [31:0] addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    // Stalled handshakes must hold their payload
    always @(posedge clk) begin
        if (!rst && rsp_stalled) begin
            check_equal("core_rsp_valid", 32'(core_rsp_valid), 32'd1);
            check_equal("core_rsp.data", core_rsp.data, stalled_rsp.data);
            check_equal("core_rsp.tag", 32'(core_rsp.tag), 32'(stalled_rsp.tag));
        end
        if (!rst && dram_stalled) begin
            check_equal("dram_req_read", 32'(dram_req_read), 32'd1);
            check_equal("dram_req_addr", 32'(dram_req_addr), 32'(stalled_addr));
            check_equal("dram_req_tag", 32'(dram_req_tag), 32'(stalled_tag));
        end
        rsp_stalled  = !rst && core_rsp_valid && !core_rsp_ready;
        stalled_rsp  = core_rsp;
        dram_stalled = !rst && dram_req_read && !dram_req_ready;
        stalled_addr = dram_req_addr;
        stalled_tag  = dram_req_tag;
    end

    task automatic send_req(input logic [31:0] addr, input logic [7:0] tag);
        int n;
        core_req_valid    = 1'b1;
        core_req.addr.raw = addr;
        core_req.tag      = tag;
        n = 0;
        @(posedge clk);
        while (!core_req_ready && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            report_timeout("core_req_ready");
        end
        #1;
        core_req_valid = 1'b0;
    endtask

    task automatic recv_rsp(input logic [7:0] tag, input logic [31:0] addr);
        int n;
        n = 0;
        @(posedge clk);
        while (!(core_rsp_valid && core_rsp_ready) && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            report_timeout("core_rsp_valid");
        end else begin
            check_equal("core_rsp.tag", 32'(core_rsp.tag), 32'(tag));
            check_equal("core_rsp.data", core_rsp.data, rule_word(addr));
        end
        #1;
    endtask

    task automatic read_and_check(input logic [31:0] addr, input logic [7:0] tag,
                                  input int new_reads);
        int unsigned reads_before;
        reads_before = read_count;
        send_req(addr, tag);
        recv_rsp(tag, addr);
        check_equal("read_count", read_count - reads_before, new_reads);
        if (new_reads > 0) begin
            check_equal("dram_req_addr", 32'(last_addr), 32'(addr[31:4]));
        end
    endtask

    task automatic test_reset_state();
        check_equal("core_rsp_valid", 32'(core_rsp_valid), 32'd0);
        check_equal("dram_req_read", 32'(dram_req_read), 32'd0);
        check_equal("core_req_ready", 32'(core_req_ready), 32'd1);
        // No bank waits for a fill yet
        check_equal("dram_rsp_ready", 32'(dram_rsp_ready), 32'd0);
    endtask

    task automatic test_miss_hit_evict();
        read_and_check(32'h0001_2348, 8'h11, 1);
        // Same line, other word
        read_and_check(32'h0001_234C, 8'h12, 0);
        // Next tag up, same set and bank
        read_and_check(32'h0001_2748, 8'h13, 1);
        read_and_check(32'h0001_2348, 8'h14, 1);
    endtask

    task automatic test_parallel();
        logic [31:0] addrs [`CACHE_NUM_BANKS];
        bit          seen  [`CACHE_NUM_BANKS];
        int unsigned reads_before;
        int          got;
        int          n;
        int          idx;
        reads_before = read_count;
        got = 0;
        for (int b = 0; b < `CACHE_NUM_BANKS; b++) begin
            addrs[b] = 32'h0008_0000 | 32'(b << 4) | 32'(b << 2);
            seen[b]  = 1'b0;
        end
        fork
            begin
                for (int b = 0; b < `CACHE_NUM_BANKS; b++) begin
                    send_req(addrs[b], 8'h40 + 8'(b));
                end
            end
            begin
                n = 0;
                while (got < `CACHE_NUM_BANKS && n < TIMEOUT) begin
                    core_rsp_ready = 1'($urandom & 1);
                    @(posedge clk);
                    if (core_rsp_valid && core_rsp_ready) begin
                        idx = int'(core_rsp.tag) - 'h40;
                        assert (idx >= 0 && idx < `CACHE_NUM_BANKS && !seen[idx]) else begin
                            errors++;
                            $display("Response tag %h is unknown or came back twice",
                                     core_rsp.tag);
                        end
                        if (idx >= 0 && idx < `CACHE_NUM_BANKS && !seen[idx]) begin
                            seen[idx] = 1'b1;
                            got++;
                            check_equal("core_rsp.data", core_rsp.data, rule_word(addrs[idx]));
                        end
                    end
                    #1;
                    n++;
                end
            end
        join
        core_rsp_ready = 1'b1;
        if (got < `CACHE_NUM_BANKS) begin
            report_timeout("all four bank responses");
        end
        check_equal("read_count", read_count - reads_before, `CACHE_NUM_BANKS);
    endtask

    task automatic test_dram_stall();
        logic [31:0] addr;
        int unsigned reads_before;
        int          n;
        addr = 32'h0030_0574;
        reads_before = read_count;
        hold_ready = 1'b1;
        @(posedge clk);
        #1;
        send_req(addr, 8'h77);
        n = 0;
        @(posedge clk);
        while (!dram_req_read && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            report_timeout("dram_req_read");
        end
        check_equal("dram_req_addr", 32'(dram_req_addr), 32'(addr[31:4]));
        check_equal("dram_req_tag", 32'(dram_req_tag), 32'(addr[31:4]));
        repeat (20) begin
            @(posedge clk);
            check_equal("dram_req_read", 32'(dram_req_read), 32'd1);
            check_equal("dram_req_addr", 32'(dram_req_addr), 32'(addr[31:4]));
        end
        #1;
        hold_ready = 1'b0;
        recv_rsp(8'h77, addr);
        check_equal("read_count", read_count - reads_before, 1);
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        core_req_valid = 1'b0;
        core_req       = '0;
        core_rsp_ready = 1'b1;
        rsp_delay      = 4;
        hold_ready     = 1'b0;
        errors         = 0;
        timeouts       = 0;
        rsp_stalled    = 1'b0;
        stalled_rsp    = '0;
        dram_stalled   = 1'b0;
        stalled_addr   = '0;
        stalled_tag    = '0;
        void'($urandom(32'hd2c8570b));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_miss_hit_evict();
        test_parallel();
        test_dram_stall();
        $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/dram_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module dram_model (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               req_read,
    input  logic [`CACHE_LINE_ADDR_BITS-1:0]   req_addr,
    input  logic [`CACHE_LINE_ADDR_BITS-1:0]   req_tag,
    output logic                               req_ready,
    output logic                               rsp_valid,
    output logic [`CACHE_LINE_BITS-1:0]        rsp_data,
    output logic [`CACHE_LINE_ADDR_BITS-1:0]   rsp_tag,
    input  logic                               rsp_ready,
    input  int unsigned                        rsp_delay,
    input  logic                               hold_ready,
    output int unsigned                        read_count,
    output logic [`CACHE_LINE_ADDR_BITS-1:0]   last_addr
);

    logic                             busy;
    int unsigned                      wait_cnt;
    logic [`CACHE_LINE_ADDR_BITS-1:0] pend_tag;

    // Each word holds its own byte address xor a fixed pattern
    function automatic logic [`CACHE_LINE_BITS-1:0] line_data(
        input logic [`CACHE_LINE_ADDR_BITS-1:0] line
    );
        logic [`CACHE_LINE_BITS-1:0] data;
        logic [31:0]                 addr;
        for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++) begin
            addr = {line, 2'(w), 2'b00};
            data[w*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] = addr ^ 32'hA5A5_0000;
        end
        return data;
    endfunction

    initial begin
        req_ready  = 1'b0;
        rsp_valid  = 1'b0;
        rsp_data   = '0;
        rsp_tag    = '0;
        busy       = 1'b0;
        wait_cnt   = 0;
        pend_tag   = '0;
        read_count = 0;
        last_addr  = '0;
    end

    // One request outstanding at a time
    always @(posedge clk) begin : model_step
        logic                             take;
        logic                             done;
        logic                             rst_s;
        logic                             hold_s;
        int unsigned                      delay_s;
        logic [`CACHE_LINE_ADDR_BITS-1:0] addr_s;
        logic [`CACHE_LINE_ADDR_BITS-1:0] tag_s;
        take    = req_read && req_ready;
        done    = rsp_valid && rsp_ready;
        rst_s   = rst;
        hold_s  = hold_ready;
        delay_s = rsp_delay;
        addr_s  = req_addr;
        tag_s   = req_tag;
        #1;
        if (rst_s) begin
            busy      = 1'b0;
            rsp_valid = 1'b0;
        end else begin
            if (done) begin
                rsp_valid = 1'b0;
                busy      = 1'b0;
            end
            if (take) begin
                busy       = 1'b1;
                pend_tag   = tag_s;
                last_addr  = addr_s;
                wait_cnt   = delay_s;
                read_count = read_count + 1;
            end else if (busy && !rsp_valid) begin
                if (wait_cnt == 0) begin
                    rsp_valid = 1'b1;
                    rsp_tag   = pend_tag;
                    rsp_data  = line_data(pend_tag);
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
        req_ready = !rst_s && !busy && !hold_s;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/cache_addr_pkg.sv
source/cache_bus_pkg.sv
source/core_req_dispatch.sv
source/bank_line_store.sv
source/cache_bank.sv
source/dram_port.sv
source/core_rsp_merge.sv
source/cache_top.sv
verification/dram_model.sv
verification/cache_tb.sv
